// ==== rv_pkg.sv ====
// RV32I subset core shared definitions
// Opcodes, ALU operations, decoded-instruction and data request structs

package rv_pkg;

  localparam int XLEN = 32;
  localparam int NREGS = 32;
  localparam int REG_AW = $clog2(NREGS);

  // Full EBREAK encoding, the only SYSTEM instruction accepted
  localparam logic [XLEN-1:0] INSTR_EBREAK = 32'h0010_0073;

  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // Multicycle controller states
  typedef enum logic [2:0] {
    ST_RESET = 3'd0,
    ST_FETCH = 3'd1,
    ST_EXEC  = 3'd2,
    ST_MEM   = 3'd3,
    ST_WB    = 3'd4,
    ST_HALT  = 3'd5
  } ctrl_state_e;

  typedef struct packed {
    alu_op_e           alu_op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm;
    logic              use_imm;
    logic              reg_we;
    logic              is_load;
    logic              is_store;
    logic              is_branch;
    logic              branch_ne;
    logic              is_jal;
    logic              is_halt;
  } dec_t;

  // One full-word data access
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

endpackage

// ==== rv_decoder.sv ====
// Instruction decoder
// Splits an RV32I word into register fields, immediate and control flags,
// and flags anything outside the supported subset as illegal

`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output dec_t            dec_o,
  output logic            illegal_o
);

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates of every format
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    dec_o        = '0;
    dec_o.alu_op = ALU_ADD;
    dec_o.rd     = instr_i[11:7];
    dec_o.rs1    = instr_i[19:15];
    dec_o.rs2    = instr_i[24:20];
    illegal_o    = 1'b0;

    case (instr_i[6:0])
      OPC_OP: begin
        dec_o.reg_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec_o.alu_op = ALU_ADD;
          10'b0100000_000: dec_o.alu_op = ALU_SUB;
          10'b0000000_111: dec_o.alu_op = ALU_AND;
          10'b0000000_110: dec_o.alu_op = ALU_OR;
          10'b0000000_100: dec_o.alu_op = ALU_XOR;
          10'b0000000_010: dec_o.alu_op = ALU_SLT;
          default:         illegal_o    = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        dec_o.reg_we  = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_i_type;
        case (funct3)
          3'b000:  dec_o.alu_op = ALU_ADD;
          3'b111:  dec_o.alu_op = ALU_AND;
          3'b110:  dec_o.alu_op = ALU_OR;
          3'b100:  dec_o.alu_op = ALU_XOR;
          default: illegal_o    = 1'b1;
        endcase
      end
      OPC_LUI: begin
        dec_o.reg_we  = 1'b1;
        dec_o.use_imm = 1'b1;
        dec_o.imm     = imm_u_type;
        dec_o.alu_op  = ALU_PASS_B;
      end
      OPC_LOAD: begin
        // Word loads only
        dec_o.reg_we  = 1'b1;
        dec_o.is_load = 1'b1;
        dec_o.imm     = imm_i_type;
        illegal_o     = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        dec_o.is_store = 1'b1;
        dec_o.imm      = imm_s_type;
        illegal_o      = (funct3 != 3'b010);
      end
      OPC_BRANCH: begin
        dec_o.is_branch = 1'b1;
        dec_o.branch_ne = funct3[0];
        dec_o.imm       = imm_b_type;
        illegal_o       = (funct3[2:1] != 2'b00);
      end
      OPC_JAL: begin
        dec_o.reg_we = 1'b1;
        dec_o.is_jal = 1'b1;
        dec_o.imm    = imm_j_type;
      end
      OPC_SYSTEM: begin
        dec_o.is_halt = (instr_i == INSTR_EBREAK);
        illegal_o     = (instr_i != INSTR_EBREAK);
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
// General-purpose register file
// x1..x31 as flops, two combinational read ports, x0 reads as zero

`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [REG_AW-1:0] raddr_a_i,
  input  logic [REG_AW-1:0] raddr_b_i,
  input  logic [REG_AW-1:0] waddr_i,
  input  logic              we_i,
  input  logic [XLEN-1:0]   wdata_i,
  output logic [XLEN-1:0]   rdata_a_o,
  output logic [XLEN-1:0]   rdata_b_o
);

  logic [XLEN-1:0] regs_q [1:NREGS-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== rv_alu.sv ====
// Integer ALU
// Add, subtract, logic ops, signed set-less-than and pass of operand b,
// plus an equality flag for branch decisions

`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            equal_o
);

  logic signed_lt;

  assign signed_lt = ($signed(a_i) < $signed(b_i));

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_OR:     result_o = a_i | b_i;
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, signed_lt};
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

  // Compare is independent of the selected op
  assign equal_o = (a_i == b_i);

endmodule

// ==== rv_fetch.sv ====
// Instruction fetch unit
// Holds the PC and the instruction register and runs one request on the
// instruction bus per start pulse

`timescale 1ns/1ps

module rv_fetch import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            start_i,
  input  logic            pc_load_i,
  input  logic [XLEN-1:0] pc_next_i,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] instr_o,
  output logic            instr_valid_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] instr_q;
  logic            req_q;
  logic            wait_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q   <= boot_addr_i;
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (pc_load_i) begin
        pc_q <= pc_next_i;
      end
      // Request stays up until the bus grants it
      if (start_i) begin
        req_q <= 1'b1;
      end else if (req_q && instr_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && instr_gnt_i) begin
        wait_q <= 1'b1;
      end else if (wait_q && instr_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wait_q && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o   = req_q;
  assign instr_addr_o  = pc_q;
  assign pc_o          = pc_q;
  assign instr_o       = instr_q;
  assign instr_valid_o = wait_q & instr_rvalid_i;

endmodule

// ==== rv_lsu.sv ====
// Load-store unit
// Latches one word access on start and runs it on the data bus,
// returning the load data once the response arrives

`timescale 1ns/1ps

module rv_lsu import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            start_i,
  input  mem_req_t        req_i,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,
  output logic            data_req_o,
  output logic            data_we_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic [XLEN-1:0] data_wdata_o,
  output logic [XLEN-1:0] rdata_o,
  output logic            done_o
);

  mem_req_t        req_q;
  logic [XLEN-1:0] rdata_q;
  logic            pend_q;
  logic            wait_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (start_i) begin
        pend_q <= 1'b1;
      end else if (pend_q && data_gnt_i) begin
        pend_q <= 1'b0;
      end
      // Stores also wait for their response
      if (pend_q && data_gnt_i) begin
        wait_q <= 1'b1;
      end else if (wait_q && data_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      req_q <= req_i;
    end
    if (wait_q && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o   = pend_q;
  assign data_we_o    = req_q.we;
  assign data_addr_o  = req_q.addr;
  assign data_wdata_o = req_q.wdata;
  assign rdata_o      = rdata_q;
  assign done_o       = wait_q & data_rvalid_i;

endmodule

// ==== rv_controller.sv ====
// Multicycle core controller
// Steps each instruction through fetch, execute, memory and writeback,
// picks operands, targets and writeback data, and halts on EBREAK

`timescale 1ns/1ps

module rv_controller import rv_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              fetch_enable_i,
  input  logic              instr_valid_i,
  input  dec_t              dec_i,
  input  logic              illegal_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   rs1_i,
  input  logic [XLEN-1:0]   rs2_i,
  input  logic [XLEN-1:0]   alu_result_i,
  input  logic              alu_equal_i,
  input  logic [XLEN-1:0]   lsu_rdata_i,
  input  logic              lsu_done_i,
  output logic              fetch_start_o,
  output logic              pc_load_o,
  output logic [XLEN-1:0]   pc_next_o,
  output alu_op_e           alu_op_o,
  output logic [XLEN-1:0]   alu_b_o,
  output logic              lsu_start_o,
  output mem_req_t          lsu_req_o,
  output logic              rf_we_o,
  output logic [REG_AW-1:0] rf_waddr_o,
  output logic [XLEN-1:0]   rf_wdata_o,
  output logic              core_sleep_o
);

  ctrl_state_e     state_q;
  ctrl_state_e     state_d;
  logic            stop;
  logic            mem_op;
  logic            taken;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_target;

  assign stop   = dec_i.is_halt | illegal_i;
  assign mem_op = dec_i.is_load | dec_i.is_store;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RESET: if (fetch_enable_i) state_d = ST_FETCH;
      ST_FETCH: if (instr_valid_i) state_d = ST_EXEC;
      ST_EXEC: begin
        if (stop) begin
          state_d = ST_HALT;
        end else if (mem_op) begin
          state_d = ST_MEM;
        end else begin
          state_d = ST_WB;
        end
      end
      ST_MEM:   if (lsu_done_i) state_d = ST_WB;
      ST_WB:    state_d = ST_FETCH;
      ST_HALT:  state_d = ST_HALT;
      default:  state_d = ST_HALT;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Operand b is either the immediate or rs2
  assign alu_op_o = dec_i.alu_op;
  assign alu_b_o  = dec_i.use_imm ? dec_i.imm : rs2_i;

  // Branch and jump targets share one adder
  assign pc_plus4  = pc_i + PC_STEP;
  assign pc_target = pc_i + dec_i.imm;
  assign taken     = dec_i.is_jal | (dec_i.is_branch & (alu_equal_i ^ dec_i.branch_ne));

  assign fetch_start_o = ((state_q == ST_RESET) && fetch_enable_i) || (state_q == ST_WB);
  assign pc_load_o     = (state_q == ST_WB);
  assign pc_next_o     = taken ? pc_target : pc_plus4;

  assign lsu_start_o     = (state_q == ST_EXEC) && mem_op && !stop;
  assign lsu_req_o.addr  = rs1_i + dec_i.imm;
  assign lsu_req_o.we    = dec_i.is_store;
  assign lsu_req_o.wdata = rs2_i;

  // Writeback source, link value for JAL
  always_comb begin
    if (dec_i.is_jal) begin
      rf_wdata_o = pc_plus4;
    end else if (dec_i.is_load) begin
      rf_wdata_o = lsu_rdata_i;
    end else begin
      rf_wdata_o = alu_result_i;
    end
  end

  assign rf_we_o      = (state_q == ST_WB) && dec_i.reg_we;
  assign rf_waddr_o   = dec_i.rd;
  assign core_sleep_o = (state_q == ST_HALT);

endmodule

// ==== rv_wrapper.sv ====
// Core top level
// Connects fetch, decode, register file, ALU, load-store unit and
// controller to the instruction and data memory buses

`timescale 1ns/1ps

module rv_wrapper import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [XLEN-1:0] boot_addr_i,
  input  logic            fetch_enable_i,
  // Instruction bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic [XLEN-1:0] instr_rdata_i,
  // Data bus
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic [XLEN-1:0] data_rdata_i,
  output logic            core_sleep_o
);

  logic              fetch_start;
  logic              pc_load;
  logic [XLEN-1:0]   pc_next;
  logic [XLEN-1:0]   pc;
  logic [XLEN-1:0]   instr;
  logic              instr_valid;
  dec_t              dec;
  logic              illegal;
  logic [XLEN-1:0]   rs1_data;
  logic [XLEN-1:0]   rs2_data;
  alu_op_e           alu_op;
  logic [XLEN-1:0]   alu_b;
  logic [XLEN-1:0]   alu_result;
  logic              alu_equal;
  logic              lsu_start;
  mem_req_t          lsu_req;
  logic [XLEN-1:0]   lsu_rdata;
  logic              lsu_done;
  logic              rf_we;
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;

  rv_fetch fetch_i (
    .clk_i, .rst_i, .boot_addr_i,
    .start_i(fetch_start), .pc_load_i(pc_load), .pc_next_i(pc_next),
    .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i, .instr_req_o, .instr_addr_o,
    .pc_o(pc), .instr_o(instr), .instr_valid_o(instr_valid)
  );

  rv_decoder decoder_i (.instr_i(instr), .dec_o(dec), .illegal_o(illegal));

  rv_regfile regfile_i (
    .clk_i, .rst_i, .raddr_a_i(dec.rs1), .raddr_b_i(dec.rs2),
    .waddr_i(rf_waddr), .we_i(rf_we), .wdata_i(rf_wdata),
    .rdata_a_o(rs1_data), .rdata_b_o(rs2_data)
  );

  rv_alu alu_i (
    .op_i(alu_op), .a_i(rs1_data), .b_i(alu_b), .result_o(alu_result), .equal_o(alu_equal)
  );

  rv_lsu lsu_i (
    .clk_i, .rst_i, .start_i(lsu_start), .req_i(lsu_req),
    .data_gnt_i, .data_rvalid_i, .data_rdata_i, .data_req_o, .data_we_o,
    .data_addr_o, .data_wdata_o, .rdata_o(lsu_rdata), .done_o(lsu_done)
  );

  rv_controller controller_i (
    .clk_i, .rst_i, .fetch_enable_i, .instr_valid_i(instr_valid), .dec_i(dec),
    .illegal_i(illegal), .pc_i(pc), .rs1_i(rs1_data), .rs2_i(rs2_data),
    .alu_result_i(alu_result), .alu_equal_i(alu_equal), .lsu_rdata_i(lsu_rdata),
    .lsu_done_i(lsu_done), .fetch_start_o(fetch_start), .pc_load_o(pc_load),
    .pc_next_o(pc_next), .alu_op_o(alu_op), .alu_b_o(alu_b), .lsu_start_o(lsu_start),
    .lsu_req_o(lsu_req), .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .core_sleep_o
  );

endmodule

// ==== tb_rv_wrapper.sv ====
// Directed testbench for the RV32I subset core
// Memory models with optional random stall, store monitor and program tests

`timescale 1ns/1ps

module tb_rv_wrapper import rv_pkg::*; ();

  localparam int CYCLE_LIMIT = 20000;

  logic            clk_i = 1'b0;
  logic            rst_i, fetch_enable_i, core_sleep_o;
  logic [XLEN-1:0] boot_addr_i;
  logic            instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [XLEN-1:0] instr_addr_o, instr_rdata_i;
  logic            data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  logic [XLEN-1:0] data_addr_o, data_wdata_o, data_rdata_i;

  logic [XLEN-1:0] imem [0:1023];
  logic [XLEN-1:0] dmem [0:255];
  logic [XLEN-1:0] prog [$];
  logic [XLEN-1:0] load_addrs [$];
  logic [XLEN-1:0] ld_words [0:3];
  logic [XLEN-1:0] ibuf_addr, dbuf_addr, first_addr;
  mem_req_t        stores [$];
  mem_req_t        exp_stores [$];
  logic [1:0]      ist, dst;
  int              icnt, dcnt, cycles, errors, seed;
  logic            slow, first_seen;
  string           cur_test;

  rv_wrapper DUT (.*);

  always #50 clk_i = ~clk_i;

  function automatic int stall();
    if (slow) return {$random(seed)} % 5;
    return 0;
  endfunction

  // Instruction memory, one transfer in flight
  always @(posedge clk_i) begin
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    if (rst_i) begin
      ist        <= 2'd0;
      first_seen <= 1'b0;
    end else begin
      case (ist)
        2'd0: if (instr_req_o) begin
          icnt <= stall();
          ist  <= 2'd1;
          if (!first_seen) begin
            first_addr <= instr_addr_o;
            first_seen <= 1'b1;
          end
        end
        2'd1: if (icnt == 0) begin
          instr_gnt_i <= 1'b1;
          ist         <= 2'd2;
        end else icnt <= icnt - 1;
        2'd2: begin
          ibuf_addr <= instr_addr_o;
          icnt      <= stall();
          ist       <= 2'd3;
        end
        default: if (icnt == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= imem[ibuf_addr[11:2]];
          ist            <= 2'd0;
        end else icnt <= icnt - 1;
      endcase
    end
  end

  // Data memory, also records every store and load address
  always @(posedge clk_i) begin
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= 1'b0;
    if (rst_i) begin
      dst <= 2'd0;
    end else begin
      case (dst)
        2'd0: if (data_req_o) begin
          dcnt <= stall();
          dst  <= 2'd1;
        end
        2'd1: if (dcnt == 0) begin
          data_gnt_i <= 1'b1;
          dst        <= 2'd2;
        end else dcnt <= dcnt - 1;
        2'd2: begin
          if (data_we_o) begin
            stores.push_back('{addr: data_addr_o, we: 1'b1, wdata: data_wdata_o});
            dmem[data_addr_o[9:2]] = data_wdata_o;
          end else load_addrs.push_back(data_addr_o);
          dbuf_addr <= data_addr_o;
          dcnt      <= stall();
          dst       <= 2'd3;
        end
        default: if (dcnt == 0) begin
          data_rvalid_i <= 1'b1;
          data_rdata_i  <= dmem[dbuf_addr[9:2]];
          dst           <= 2'd0;
        end else dcnt <= dcnt - 1;
      endcase
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: core never reached sleep in test %s, state %s", cur_test,
               DUT.controller_i.state_q.name());
      $display("Simulation failed");
      $finish;
    end
  end

  // Hand assembly helpers
  function automatic logic [31:0] reg_instr(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction
  function automatic logic [31:0] imm_instr(int imm, int rs1, int f3, int rd,
                                            logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction
  function automatic logic [31:0] branch_instr(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction
  function automatic logic [31:0] jal_instr(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic add_store(int rs2, int addr, logic [XLEN-1:0] val);
    prog.push_back({addr[11:5], rs2[4:0], 5'd0, 3'b010, addr[4:0], 7'h23});
    exp_stores.push_back('{addr: XLEN'(addr), we: 1'b1, wdata: val});
  endtask

  task automatic check_word(int addr, logic [XLEN-1:0] exp);
    if (dmem[addr[9:2]] !== exp) begin
      errors++;
      $display("Error at %0t: %s word at %h is %h, expected %h", $time, cur_test,
               addr, dmem[addr[9:2]], exp);
    end
  endtask

  task automatic check_store(mem_req_t got, mem_req_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s store %h=%h, expected %h=%h", $time, cur_test,
               got.addr, got.wdata, exp.addr, exp.wdata);
    end
  endtask

  task automatic check_sleep(logic exp, int n);
    repeat (n) begin
      @(posedge clk_i);
      if (core_sleep_o !== exp || instr_req_o || data_req_o) begin
        errors++;
        $display("Error at %0t: %s sleep %b or request seen, expected sleep %b", $time,
                 cur_test, core_sleep_o, exp);
      end
    end
  endtask

  task automatic run_program(logic [XLEN-1:0] boot);
    stores.delete();
    load_addrs.delete();
    for (int i = 0; i < 1024; i++) imem[i] = '0;
    foreach (prog[i]) imem[boot[11:2] + i] = prog[i];
    rst_i          <= 1'b1;
    fetch_enable_i <= 1'b0;
    boot_addr_i    <= boot;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    check_sleep(1'b0, 4);
    fetch_enable_i <= 1'b1;
    while (!core_sleep_o) @(posedge clk_i);
    if (first_addr !== boot) begin
      errors++;
      $display("Error at %0t: %s first fetch %h, expected %h", $time, cur_test,
               first_addr, boot);
    end
    check_sleep(1'b1, 50);
    if (stores.size() != exp_stores.size()) begin
      errors++;
      $display("Error at %0t: %s saw %0d stores, expected %0d", $time, cur_test,
               stores.size(), exp_stores.size());
    end else foreach (stores[i]) check_store(stores[i], exp_stores[i]);
  endtask

  task automatic alu_test(logic [XLEN-1:0] boot);
    logic [XLEN-1:0] v [1:13];
    cur_test = "alu";
    prog.delete();
    exp_stores.delete();
    v[1] = 32'h1234_5000;
    v[2] = -32'sd5;
    v[3] = 32'd7;
    v[4] = v[1] + v[3];
    v[5] = v[2] - v[3];
    v[6] = {31'd0, $signed(v[2]) < $signed(v[3])};
    v[7] = {31'd0, $signed(v[3]) < $signed(v[2])};
    v[8] = v[1] & v[2];
    v[9] = v[1] | v[3];
    v[10] = v[2] ^ v[3];
    v[11] = v[2] & 32'h7f0;
    v[12] = v[3] | 32'hffff_ff00;
    v[13] = ~v[2];
    prog.push_back({20'h12345, 5'd1, 7'h37});
    prog.push_back(imm_instr(-5, 0, 0, 2, 7'h13));
    prog.push_back(imm_instr(7, 0, 0, 3, 7'h13));
    prog.push_back(reg_instr(0, 3, 1, 0, 4));
    prog.push_back(reg_instr(32, 3, 2, 0, 5));
    prog.push_back(reg_instr(0, 3, 2, 2, 6));
    prog.push_back(reg_instr(0, 2, 3, 2, 7));
    prog.push_back(reg_instr(0, 2, 1, 7, 8));
    prog.push_back(reg_instr(0, 3, 1, 6, 9));
    prog.push_back(reg_instr(0, 3, 2, 4, 10));
    prog.push_back(imm_instr(32'h7f0, 2, 7, 11, 7'h13));
    prog.push_back(imm_instr(-256, 3, 6, 12, 7'h13));
    prog.push_back(imm_instr(-1, 2, 4, 13, 7'h13));
    prog.push_back(imm_instr(5, 0, 0, 0, 7'h13));
    for (int r = 4; r <= 13; r++) add_store(r, 32'h100 + 4 * (r - 4), v[r]);
    add_store(0, 32'h140, '0);
    prog.push_back(INSTR_EBREAK);
    run_program(boot);
  endtask

  task automatic load_store_test(logic [XLEN-1:0] boot);
    cur_test = "load_store";
    prog.delete();
    exp_stores.delete();
    for (int i = 0; i < 4; i++) dmem[16 + i] = ld_words[i];
    prog.push_back(imm_instr(32'h40, 0, 2, 1, 7'h03));
    prog.push_back(imm_instr(32'h44, 0, 2, 2, 7'h03));
    prog.push_back(reg_instr(0, 2, 1, 0, 3));
    add_store(3, 32'h80, ld_words[0] + ld_words[1]);
    prog.push_back(imm_instr(32'h48, 0, 2, 4, 7'h03));
    prog.push_back(reg_instr(32, 1, 4, 0, 5));
    add_store(5, 32'h84, ld_words[2] - ld_words[0]);
    add_store(1, 32'h88, ld_words[0]);
    prog.push_back(INSTR_EBREAK);
    run_program(boot);
    check_word(32'h84, ld_words[2] - ld_words[0]);
    foreach (load_addrs[i]) begin
      if (load_addrs[i] >= 32'h80 && load_addrs[i] <= 32'h88) begin
        errors++;
        $display("Read request went to store address %h in %s", load_addrs[i], cur_test);
      end
    end
  endtask

  task automatic branch_test(logic [XLEN-1:0] boot);
    int acc;
    cur_test = "branch";
    prog.delete();
    exp_stores.delete();
    acc = 0;
    for (int n = 5; n > 0; n--) acc += 3;
    prog.push_back(imm_instr(5, 0, 0, 1, 7'h13));
    prog.push_back(imm_instr(0, 0, 0, 2, 7'h13));
    prog.push_back(imm_instr(3, 2, 0, 2, 7'h13));
    prog.push_back(imm_instr(-1, 1, 0, 1, 7'h13));
    prog.push_back(branch_instr(-8, 0, 1, 1));
    prog.push_back(branch_instr(8, 0, 1, 0));
    prog.push_back({7'd6, 5'd2, 5'd0, 3'b010, 5'd0, 7'h23});
    // A wrongly taken BNE here lands on the skipped store at 0xc4
    prog.push_back(branch_instr(12, 0, 1, 1));
    prog.push_back(branch_instr(8, 0, 2, 0));
    prog.push_back(jal_instr(12, 5));
    prog.push_back({7'd6, 5'd1, 5'd0, 3'b010, 5'd4, 7'h23});
    prog.push_back({7'd6, 5'd1, 5'd0, 3'b010, 5'd8, 7'h23});
    add_store(2, 32'hd0, XLEN'(acc));
    add_store(5, 32'hd4, boot + 32'd40);
    prog.push_back(INSTR_EBREAK);
    run_program(boot);
  endtask

  task automatic illegal_test(logic [XLEN-1:0] boot);
    cur_test = "illegal";
    prog.delete();
    exp_stores.delete();
    prog.push_back(imm_instr(1, 0, 0, 1, 7'h13));
    add_store(1, 32'h90, 32'd1);
    prog.push_back(32'hffff_ffff);
    prog.push_back({7'd4, 5'd1, 5'd0, 3'b010, 5'h14, 7'h23});
    run_program(boot);
  endtask

  initial begin
    seed           = 32'h52be;
    errors         = 0;
    cycles         = 0;
    slow           = 1'b0;
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = '0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    for (int i = 0; i < 256; i++) dmem[i] = 32'hd000_0000 ^ (i * 32'h0101_0004);
    for (int i = 0; i < 4; i++) ld_words[i] = $random(seed);
    alu_test(32'h0);
    load_store_test(32'h0);
    branch_test(32'h400);
    // Same programs with random grant and response stalls
    slow = 1'b1;
    alu_test(32'h400);
    load_store_test(32'h0);
    branch_test(32'h0);
    illegal_test(32'h200);
    $display("Checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_fetch.sv
rv_lsu.sv
rv_controller.sv
rv_wrapper.sv
tb_rv_wrapper.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the core testbench with Verilator

verilator --binary --timing -f flist.f --top-module tb_rv_wrapper -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "Build or run did not complete"; exit 1; }

grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
